//--- src/leaf_pkg.sv
package leaf_pkg;

    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int tag_bits     = 7;

    // Packet fields run from the top bit down as valid, leaf, port, tag and payload
    localparam int valid_pos   = packet_bits - 1;
    localparam int leaf_lsb    = valid_pos - leaf_bits;     // Bits 47:43
    localparam int port_lsb    = leaf_lsb - port_bits;      // Bits 42:39
    localparam int tag_lsb     = port_lsb - tag_bits;       // Bits 38:32
    localparam int payload_lsb = tag_lsb - payload_bits;    // Bits 31:0

    // Address of this leaf in the tree
    localparam logic [leaf_bits-1:0] leaf_id = 5'd5;

    localparam int num_in_ports    = 3;
    localparam int queue_depth     = 8;
    localparam int queue_addr_bits = 3;

    typedef enum logic [0:0] {
        ctrl_halt = 1'b0,   // Kernel held in reset
        ctrl_run  = 1'b1
    } ctrl_state_t;

    // Opcodes sit in the tag field of packets sent to port 0
    typedef enum logic [tag_bits-1:0] {
        op_set_dest = 7'h01,    // Payload bits 8:4 give the leaf, bits 3:0 the port
        op_start    = 7'h02,
        op_halt     = 7'h03
    } ctrl_op_t;

endpackage

//--- src/leaf_ctrl.sv
`timescale 1ns/1ps

module leaf_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [leaf_pkg::packet_bits-1:0]      din_leaf_bft2interface,
    input  logic                                  ap_start,
    input  logic [leaf_pkg::num_in_ports-1:0]     full,
    output logic [leaf_pkg::num_in_ports-1:0]     push,
    output logic [leaf_pkg::payload_bits-1:0]     push_data,
    output logic [leaf_pkg::leaf_bits-1:0]        dest_leaf,
    output logic [leaf_pkg::port_bits-1:0]        dest_port,
    output logic                                  kernel_rst_n
);

    logic                                  pkt_valid;
    logic [leaf_pkg::leaf_bits-1:0]        pkt_leaf;
    logic [leaf_pkg::port_bits-1:0]        pkt_port;
    leaf_pkg::ctrl_op_t                    pkt_op;
    logic [leaf_pkg::payload_bits-1:0]     pkt_payload;
    logic                                  leaf_hit;
    logic                                  is_ctrl;
    logic [leaf_pkg::num_in_ports-1:0]     push_next;
    leaf_pkg::ctrl_state_t                 state;

    assign pkt_valid   = din_leaf_bft2interface[leaf_pkg::valid_pos];
    assign pkt_leaf    = din_leaf_bft2interface[leaf_pkg::leaf_lsb +: leaf_pkg::leaf_bits];
    assign pkt_port    = din_leaf_bft2interface[leaf_pkg::port_lsb +: leaf_pkg::port_bits];
    assign pkt_op      = leaf_pkg::ctrl_op_t'(
                             din_leaf_bft2interface[leaf_pkg::tag_lsb +: leaf_pkg::tag_bits]);
    assign pkt_payload =
        din_leaf_bft2interface[leaf_pkg::payload_lsb +: leaf_pkg::payload_bits];

    assign leaf_hit = pkt_valid && (pkt_leaf == leaf_pkg::leaf_id);
    assign is_ctrl  = leaf_hit && (pkt_port == '0);     // Port 0 carries control traffic

    // Data ports 1 to 3 map onto queues 0 to 2, ports above 3 match nothing
    always_comb begin
        for (int i = 0; i < leaf_pkg::num_in_ports; i++) begin
            push_next[i] = leaf_hit && (int'(pkt_port) == i + 1) && !full[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push <= '0;
        end else begin
            push <= push_next;
        end
    end

    always_ff @(posedge clk) begin
        push_data <= pkt_payload;   // Shared by all queues, qualified by push
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= leaf_pkg::ctrl_halt;
            dest_leaf <= '0;
            dest_port <= '0;
        end else begin
            if (ap_start) begin
                state <= leaf_pkg::ctrl_run;
            end
            // A control packet in the same cycle wins over ap_start
            if (is_ctrl) begin
                case (pkt_op)
                    leaf_pkg::op_set_dest: begin
                        dest_leaf <= pkt_payload[leaf_pkg::port_bits +: leaf_pkg::leaf_bits];
                        dest_port <= pkt_payload[0 +: leaf_pkg::port_bits];
                    end
                    leaf_pkg::op_start: begin
                        state <= leaf_pkg::ctrl_run;
                    end
                    leaf_pkg::op_halt: begin
                        state <= leaf_pkg::ctrl_halt;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign kernel_rst_n = (state == leaf_pkg::ctrl_run);    // Follows the state register

endmodule

//--- src/leaf_in_port.sv
`timescale 1ns/1ps

module leaf_in_port (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 push,
    input  logic [leaf_pkg::payload_bits-1:0]    push_data,
    output logic                                 full,
    output logic                                 vld_interface2user,
    output logic [leaf_pkg::payload_bits-1:0]    dout_leaf_interface2user,
    input  logic                                 ack_user2interface
);

    logic [leaf_pkg::payload_bits-1:0]      mem [leaf_pkg::queue_depth];
    logic [leaf_pkg::queue_addr_bits-1:0]   wr_ptr;
    logic [leaf_pkg::queue_addr_bits-1:0]   rd_ptr;
    logic [leaf_pkg::queue_addr_bits:0]     count;
    logic                                   wr_en;
    logic                                   rd_en;

    // Depth is a power of two, so the count's top bit alone marks full
    assign full = count[leaf_pkg::queue_addr_bits];

    assign vld_interface2user       = (count != '0);
    assign dout_leaf_interface2user = mem[rd_ptr];      // Oldest word shown as a level

    assign wr_en = push && !full;   // A push into a full queue is lost
    assign rd_en = vld_interface2user && ack_user2interface;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at the queue depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/sum3_kernel.sv
`timescale 1ns/1ps

module sum3_kernel (
    input  logic                                 clk,
    input  logic                                 kernel_rst_n,
    input  logic [leaf_pkg::num_in_ports-1:0]    vld_interface2user,
    input  logic [leaf_pkg::payload_bits-1:0]    dout_leaf_interface2user_1,
    input  logic [leaf_pkg::payload_bits-1:0]    dout_leaf_interface2user_2,
    input  logic [leaf_pkg::payload_bits-1:0]    dout_leaf_interface2user_3,
    output logic [leaf_pkg::num_in_ports-1:0]    ack_user2interface,
    output logic [leaf_pkg::payload_bits-1:0]    din_leaf_user2interface_1,
    output logic                                 vld_user2interface_1,
    input  logic                                 ack_interface2user_1
);

    logic                                  take;
    logic                                  result_vld;
    logic [leaf_pkg::payload_bits-1:0]     result;

    // Result register is free when empty or being taken by the output stage
    assign take = kernel_rst_n && (&vld_interface2user) &&
                  (!result_vld || ack_interface2user_1);

    assign ack_user2interface = {leaf_pkg::num_in_ports{take}};

    always_ff @(posedge clk) begin
        if (!kernel_rst_n) begin
            result_vld <= 1'b0;
        end else if (take) begin
            result_vld <= 1'b1;
        end else if (ack_interface2user_1) begin
            result_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            result <= dout_leaf_interface2user_1 + dout_leaf_interface2user_2 +
                      dout_leaf_interface2user_3;   // Wraps modulo 2^32
        end
    end

    assign din_leaf_user2interface_1 = result;
    assign vld_user2interface_1      = result_vld;

endmodule

//--- src/leaf_out_port.sv
`timescale 1ns/1ps

module leaf_out_port (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [leaf_pkg::payload_bits-1:0]    din_leaf_user2interface,
    input  logic                                 vld_user2interface,
    output logic                                 ack_interface2user,
    input  logic [leaf_pkg::leaf_bits-1:0]       dest_leaf,
    input  logic [leaf_pkg::port_bits-1:0]       dest_port,
    input  logic                                 resend,
    output logic [leaf_pkg::packet_bits-1:0]     dout_leaf_interface2bft
);

    logic                                  pkt_vld;
    logic [leaf_pkg::payload_bits-1:0]     pkt_data;
    logic [leaf_pkg::leaf_bits-1:0]        pkt_leaf;
    logic [leaf_pkg::port_bits-1:0]        pkt_port;
    logic [leaf_pkg::tag_bits-1:0]         pkt_tag;
    logic [leaf_pkg::tag_bits-1:0]         tag_cnt;
    logic                                  emit;
    logic                                  take;

    // The held packet goes out in the first cycle without resend
    assign emit = pkt_vld && !resend;

    assign ack_interface2user = !resend && (!pkt_vld || emit);
    assign take = vld_user2interface && ack_interface2user;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_vld <= 1'b0;
            tag_cnt <= '0;
        end else if (take) begin
            pkt_vld <= 1'b1;
            tag_cnt <= tag_cnt + 1'b1;  // Seven bits, wraps after 127
        end else if (emit) begin
            pkt_vld <= 1'b0;
        end
    end

    // Destination is sampled with the result and stays fixed while held
    always_ff @(posedge clk) begin
        if (take) begin
            pkt_data <= din_leaf_user2interface;
            pkt_leaf <= dest_leaf;
            pkt_port <= dest_port;
            pkt_tag  <= tag_cnt;
        end
    end

    always_comb begin
        dout_leaf_interface2bft = '0;   // All zeros when idle or under resend
        if (emit) begin
            dout_leaf_interface2bft[leaf_pkg::valid_pos] = 1'b1;
            dout_leaf_interface2bft[leaf_pkg::leaf_lsb +: leaf_pkg::leaf_bits] = pkt_leaf;
            dout_leaf_interface2bft[leaf_pkg::port_lsb +: leaf_pkg::port_bits] = pkt_port;
            dout_leaf_interface2bft[leaf_pkg::tag_lsb +: leaf_pkg::tag_bits]   = pkt_tag;
            dout_leaf_interface2bft[leaf_pkg::payload_lsb +: leaf_pkg::payload_bits] =
                pkt_data;
        end
    end

endmodule

//--- src/leaf_i3o1.sv
`timescale 1ns/1ps

module leaf_i3o1 (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [leaf_pkg::packet_bits-1:0]   din_leaf_bft2interface,
    output logic [leaf_pkg::packet_bits-1:0]   dout_leaf_interface2bft,
    input  logic                               resend,
    input  logic                               ap_start
);

    logic [leaf_pkg::num_in_ports-1:0]     push;
    logic [leaf_pkg::payload_bits-1:0]     push_data;
    logic [leaf_pkg::num_in_ports-1:0]     full;
    logic [leaf_pkg::leaf_bits-1:0]        dest_leaf;
    logic [leaf_pkg::port_bits-1:0]        dest_port;
    logic                                  kernel_rst_n;

    // Bit 0 belongs to tree port 1, bit 2 to tree port 3
    logic [leaf_pkg::num_in_ports-1:0]     vld_interface2user;
    logic [leaf_pkg::num_in_ports-1:0]     ack_user2interface;
    logic [leaf_pkg::payload_bits-1:0]     dout_leaf_interface2user_1;
    logic [leaf_pkg::payload_bits-1:0]     dout_leaf_interface2user_2;
    logic [leaf_pkg::payload_bits-1:0]     dout_leaf_interface2user_3;

    logic [leaf_pkg::payload_bits-1:0]     din_leaf_user2interface_1;
    logic                                  vld_user2interface_1;
    logic                                  ack_interface2user_1;

    leaf_ctrl leaf_ctrl_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .ap_start               (ap_start),
        .full                   (full),
        .push                   (push),
        .push_data              (push_data),
        .dest_leaf              (dest_leaf),
        .dest_port              (dest_port),
        .kernel_rst_n           (kernel_rst_n)
    );

    leaf_in_port leaf_in_port_1 (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .push                     (push[0]),
        .push_data                (push_data),
        .full                     (full[0]),
        .vld_interface2user       (vld_interface2user[0]),
        .dout_leaf_interface2user (dout_leaf_interface2user_1),
        .ack_user2interface       (ack_user2interface[0])
    );

    leaf_in_port leaf_in_port_2 (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .push                     (push[1]),
        .push_data                (push_data),
        .full                     (full[1]),
        .vld_interface2user       (vld_interface2user[1]),
        .dout_leaf_interface2user (dout_leaf_interface2user_2),
        .ack_user2interface       (ack_user2interface[1])
    );

    leaf_in_port leaf_in_port_3 (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .push                     (push[2]),
        .push_data                (push_data),
        .full                     (full[2]),
        .vld_interface2user       (vld_interface2user[2]),
        .dout_leaf_interface2user (dout_leaf_interface2user_3),
        .ack_user2interface       (ack_user2interface[2])
    );

    sum3_kernel sum3_kernel_i (
        .clk                        (clk),
        .kernel_rst_n               (kernel_rst_n),
        .vld_interface2user         (vld_interface2user),
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .dout_leaf_interface2user_2 (dout_leaf_interface2user_2),
        .dout_leaf_interface2user_3 (dout_leaf_interface2user_3),
        .ack_user2interface         (ack_user2interface),
        .din_leaf_user2interface_1  (din_leaf_user2interface_1),
        .vld_user2interface_1       (vld_user2interface_1),
        .ack_interface2user_1       (ack_interface2user_1)
    );

    leaf_out_port leaf_out_port_i (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_user2interface (din_leaf_user2interface_1),
        .vld_user2interface      (vld_user2interface_1),
        .ack_interface2user      (ack_interface2user_1),
        .dest_leaf               (dest_leaf),
        .dest_port               (dest_port),
        .resend                  (resend),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

//--- sim/leaf_checker.sv
`timescale 1ns/1ps

module leaf_checker (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [leaf_pkg::packet_bits-1:0]    din_leaf_bft2interface,
    input  logic [leaf_pkg::packet_bits-1:0]    dout_leaf_interface2bft,
    input  logic                                resend,
    input  logic                                ap_start,
    input  int                                  test_num,
    output int                                  errors,
    output int                                  packets,
    output int                                  pending
);

    logic [leaf_pkg::payload_bits-1:0]    q1 [$];
    logic [leaf_pkg::payload_bits-1:0]    q2 [$];
    logic [leaf_pkg::payload_bits-1:0]    q3 [$];
    logic [leaf_pkg::packet_bits-1:0]     expected [$];
    logic                                 running;
    logic [leaf_pkg::leaf_bits-1:0]       dest_leaf;
    logic [leaf_pkg::port_bits-1:0]       dest_port;
    logic [leaf_pkg::tag_bits-1:0]        tag;
    int                                   last_test;
    int                                   test_errors;
    int                                   test_packets;

    initial begin
        errors = 0;
        packets = 0;
        pending = 0;
        last_test = 0;
        test_errors = 0;
        test_packets = 0;
    end

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic reset_model();
        q1.delete();
        q2.delete();
        q3.delete();
        expected.delete();
        running = 1'b0;
        dest_leaf = '0;
        dest_port = '0;
        tag = '0;
    endtask

    // Fields sit at valid 48, leaf 47:43, port 42:39, tag 38:32 and payload 31:0
    task automatic take_input();
        logic [leaf_pkg::packet_bits-1:0]     pkt;
        logic [leaf_pkg::tag_bits-1:0]        op;
        logic [leaf_pkg::payload_bits-1:0]    payload;
        pkt = din_leaf_bft2interface;
        op = pkt[38:32];
        payload = pkt[31:0];
        if (ap_start) begin
            running = 1'b1;
        end
        if (pkt[48] && pkt[47:43] == leaf_pkg::leaf_id) begin
            case (pkt[42:39])
                4'd0: begin
                    if (op == leaf_pkg::op_set_dest) begin
                        dest_leaf = payload[8:4];
                        dest_port = payload[3:0];
                    end else if (op == leaf_pkg::op_start) begin
                        running = 1'b1;
                    end else if (op == leaf_pkg::op_halt) begin
                        running = 1'b0;
                    end
                end
                4'd1: q1.push_back(payload);
                4'd2: q2.push_back(payload);
                4'd3: q3.push_back(payload);
                default: begin
                end
            endcase
        end
    endtask

    task automatic pair_words();
        logic [leaf_pkg::payload_bits-1:0] sum;
        while (running && q1.size() > 0 && q2.size() > 0 && q3.size() > 0) begin
            sum = q1.pop_front() + q2.pop_front() + q3.pop_front();     // Modulo 2^32
            expected.push_back({1'b1, dest_leaf, dest_port, tag, sum});
            tag = tag + 7'd1;
        end
    endtask

    task automatic check_output();
        logic [leaf_pkg::packet_bits-1:0] exp;
        if (resend && dout_leaf_interface2bft !== '0) begin
            $display("Fail dout_leaf_interface2bft under resend: expected %h, got %h",
                     49'h0, dout_leaf_interface2bft);
            note_error();
        end else if (dout_leaf_interface2bft[48] === 1'b1) begin
            if (expected.size() == 0) begin
                $display("Output packet %h appeared while no sum was pending",
                         dout_leaf_interface2bft);
                note_error();
            end else begin
                exp = expected.pop_front();
                packets++;
                test_packets++;
                if (dout_leaf_interface2bft !== exp) begin
                    $display("Fail dout_leaf_interface2bft: expected %h, got %h",
                             exp, dout_leaf_interface2bft);
                    note_error();
                end
            end
        end else if (dout_leaf_interface2bft !== '0) begin
            $display("Fail dout_leaf_interface2bft without a packet: expected %h, got %h",
                     49'h0, dout_leaf_interface2bft);
            note_error();
        end
    endtask

    // Inputs are driven on the rising edge, so everything is settled here
    always @(negedge clk) begin
        if (!rst_n) begin
            reset_model();
            if (dout_leaf_interface2bft !== '0) begin
                $display("Fail dout_leaf_interface2bft in reset: expected %h, got %h",
                         49'h0, dout_leaf_interface2bft);
                note_error();
            end
        end else begin
            check_output();
            take_input();
            pair_words();
        end
        if (test_num != last_test) begin
            if (last_test != 0) begin
                $display("Test %0d finished: %0d packets checked, %0d errors",
                         last_test, test_packets, test_errors);
            end
            if (test_num < 0 && expected.size() != 0) begin
                $display("%0d expected output packets never appeared", expected.size());
                note_error();
            end
            last_test = test_num;
            test_packets = 0;
            test_errors = 0;
        end
        pending = expected.size();
    end

endmodule

//--- sim/tb_leaf_i3o1.sv
`timescale 1ns/1ps

module tb_leaf_i3o1;

    localparam int k_idle  = 0;
    localparam int k_ctrl  = 1;
    localparam int k_data  = 2;
    localparam int k_wrong = 3;
    localparam int k_start = 4;

    logic                                clk;
    logic                                rst_n;
    logic [leaf_pkg::packet_bits-1:0]    din_leaf_bft2interface;
    logic [leaf_pkg::packet_bits-1:0]    dout_leaf_interface2bft;
    logic                                resend;
    logic                                ap_start;

    int             test_num;
    int             errors;
    int             packets;
    int             pending;
    int             cycles;
    int             limit;
    logic [31:0]    lfsr;

    // Stimulus table, one entry per row in each queue
    int kind_q [$];
    int port_q [$];
    int op_q [$];
    int arg_q [$];
    int resend_q [$];
    int test_q [$];

    leaf_i3o1 leaf_i3o1_i (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    leaf_checker check_i (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start),
        .test_num                (test_num),
        .errors                  (errors),
        .packets                 (packets),
        .pending                 (pending)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;    // Taps 32, 30, 26, 25
        end
        return s >> 1;
    endfunction

    task automatic next_payload(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    function automatic logic [leaf_pkg::packet_bits-1:0] make_packet(
        input logic [leaf_pkg::leaf_bits-1:0]     leaf,
        input logic [leaf_pkg::port_bits-1:0]     port,
        input logic [leaf_pkg::tag_bits-1:0]      tag,
        input logic [leaf_pkg::payload_bits-1:0]  payload
    );
        return {1'b1, leaf, port, tag, payload};
    endfunction

    task automatic add_row(input int test, input int kind, input int port, input int op,
                           input int arg, input int rs);
        test_q.push_back(test);
        kind_q.push_back(kind);
        port_q.push_back(port);
        op_q.push_back(op);
        arg_q.push_back(arg);
        resend_q.push_back(rs);
    endtask

    task automatic add_idle(input int n, input int test, input int rs);
        for (int i = 0; i < n; i++) begin
            add_row(test, k_idle, 0, 0, 0, rs);
        end
    endtask

    task automatic add_data3(input int test, input int rs);
        for (int p = 1; p <= 3; p++) begin
            add_row(test, k_data, p, 0, 0, rs);
        end
    endtask

    task automatic build_table();
        int order [9] = '{1, 1, 2, 3, 3, 1, 2, 2, 3};
        add_data3(1, 0);                // Kernel still halted after reset
        add_idle(3, 1, 0);
        add_row(1, k_start, 0, 0, 0, 0);
        add_idle(8, 1, 0);
        add_row(2, k_ctrl, 0, leaf_pkg::op_set_dest, 32'h92, 0);   // Leaf 9, port 2
        add_idle(2, 2, 0);
        for (int s = 0; s < 3; s++) begin
            add_data3(2, 0);
        end
        add_idle(8, 2, 0);
        for (int i = 0; i < 9; i++) begin
            add_row(3, k_data, order[i], 0, 0, 0);
        end
        add_idle(10, 3, 0);
        add_row(4, k_wrong, 1, 0, 0, 0);
        add_row(4, k_wrong, 0, leaf_pkg::op_halt, 0, 0);
        add_row(4, k_data, 5, 0, 0, 0);
        add_row(4, k_data, 15, 0, 0, 0);
        add_row(4, k_ctrl, 0, 7'h7f, 0, 0);
        add_idle(6, 4, 0);
        add_data3(4, 0);
        add_idle(8, 4, 0);
        add_data3(5, 0);
        add_idle(3, 5, 0);
        add_idle(4, 5, 1);              // First sum is held in the output stage
        add_data3(5, 1);
        add_idle(3, 5, 1);
        add_idle(10, 5, 0);
        add_row(6, k_ctrl, 0, leaf_pkg::op_halt, 0, 0);
        add_idle(2, 6, 0);
        add_data3(6, 0);
        add_data3(6, 0);
        add_idle(8, 6, 0);
        add_row(6, k_ctrl, 0, leaf_pkg::op_start, 0, 0);
        add_idle(10, 6, 0);
    endtask

    task automatic apply_row(input int i);
        logic [31:0] payload;
        payload = '0;
        test_num <= test_q[i];
        resend <= (resend_q[i] != 0);
        ap_start <= (kind_q[i] == k_start);
        case (kind_q[i])
            k_ctrl: begin
                din_leaf_bft2interface <= make_packet(leaf_pkg::leaf_id, 4'd0,
                                                      7'(op_q[i]), arg_q[i]);
            end
            k_data: begin
                next_payload(payload);
                din_leaf_bft2interface <= make_packet(leaf_pkg::leaf_id, 4'(port_q[i]),
                                                      7'd0, payload);
            end
            k_wrong: begin
                next_payload(payload);
                din_leaf_bft2interface <= make_packet(leaf_pkg::leaf_id ^ 5'd1,
                                                      4'(port_q[i]), 7'(op_q[i]), payload);
            end
            default: din_leaf_bft2interface <= '0;
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: the run did not end within %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int waited;
        clk = 1'b0;
        rst_n = 1'b0;
        din_leaf_bft2interface = '0;
        resend = 1'b0;
        ap_start = 1'b0;
        test_num = 0;
        cycles = 0;
        waited = 0;
        lfsr = 32'h1986;
        build_table();
        limit = kind_q.size() * 4 + 200;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < kind_q.size(); i++) begin
            @(posedge clk);
            apply_row(i);
        end
        @(posedge clk);
        din_leaf_bft2interface <= '0;
        resend <= 1'b0;
        ap_start <= 1'b0;
        while (pending != 0 && waited < 50) begin  // Let the last sums drain
            @(posedge clk);
            waited++;
        end
        test_num <= -1;
        repeat (2) @(posedge clk);
        $display("Checked %0d output packets, %0d errors", packets, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
src/leaf_pkg.sv
src/leaf_ctrl.sv
src/leaf_in_port.sv
src/sum3_kernel.sv
src/leaf_out_port.sv
src/leaf_i3o1.sv
sim/leaf_checker.sv
sim/tb_leaf_i3o1.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_leaf_i3o1
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
